//--- rtl/screen_pkg.sv
//////////////////////////////////////////////////////////////////////
// Shared definitions for the screen area adjustment logic
// Count type, keyboard event codes and horizontal step
// Adjust opcode enum and the packed records passed between blocks
//////////////////////////////////////////////////////////////////////

package screen_pkg;

	// Pixel or line count for counters, offsets and sizes
	typedef logic [11:0] count_t;

	localparam logic [1:0] kbd_key_type = 2'd3;  // Event carries a keycode

	localparam logic [7:0] key_backspace = 8'h41;
	localparam logic [7:0] key_up        = 8'h4C;
	localparam logic [7:0] key_down      = 8'h4D;
	localparam logic [7:0] key_right     = 8'h4E;
	localparam logic [7:0] key_left      = 8'h4F;
	localparam logic [7:0] key_alt_l     = 8'h64;
	localparam logic [7:0] key_alt_r     = 8'h65;
	localparam logic [7:0] key_alt_l_rel = 8'hE4;  // Release codes have bit 7 set
	localparam logic [7:0] key_alt_r_rel = 8'hE5;

	localparam count_t hstep = 12'd4;  // Horizontal offset step

	typedef enum logic [2:0] {
		op_none,
		op_clear,
		op_up,
		op_down,
		op_left,
		op_right,
		op_alt_on,
		op_alt_off
	} adjust_op_e;

	typedef struct packed {
		logic       valid;
		adjust_op_e op;
	} adjust_cmd_t;

	typedef struct packed {
		count_t hbl_l;
		count_t hbl_r;
		count_t vbl_t;
		count_t vbl_b;
	} crop_t;

	// Syncs are active low, blanks active high
	typedef struct packed {
		logic hs_n;
		logic vs_n;
		logic hblank;
		logic vblank;
	} video_in_t;

	typedef struct packed {
		count_t hsize;
		count_t vsize;
	} geometry_t;

	typedef struct packed {
		crop_t      crop;
		geometry_t  geometry;
		logic [6:0] change_count;
	} screen_info_t;

endpackage

//--- rtl/key_decode.sv
//////////////////////////////////////////////////////////////////////
// Keyboard event decoder
// Toggle detection on the event level and keycode to opcode mapping
//////////////////////////////////////////////////////////////////////

`timescale 1ns/100ps

module key_decode (
	input  logic                    clk_sys,
	input  logic                    reset,
	input  logic [7:0]              kbd_data,
	input  logic [1:0]              kbd_type,
	input  logic                    kbd_level,  // Toggles once per event
	output screen_pkg::adjust_cmd_t cmd
);
	import screen_pkg::*;

	logic       level_q;
	logic       event_q;
	logic [7:0] code_q;
	adjust_op_e op_dec;

	// Edge stage
	always_ff @(posedge clk_sys or posedge reset) begin
		if (reset) begin
			level_q <= 1'b0;
			event_q <= 1'b0;
		end else begin
			level_q <= kbd_level;
			event_q <= (level_q ^ kbd_level) && (kbd_type == kbd_key_type);
		end
	end

	always_ff @(posedge clk_sys) begin
		if (level_q ^ kbd_level)
			code_q <= kbd_data;  // Hold code of the latest event
	end

	always_comb begin
		case (code_q)
			key_backspace:                op_dec = op_clear;
			key_up:                       op_dec = op_up;
			key_down:                     op_dec = op_down;
			key_left:                     op_dec = op_left;
			key_right:                    op_dec = op_right;
			key_alt_l, key_alt_r:         op_dec = op_alt_on;
			key_alt_l_rel, key_alt_r_rel: op_dec = op_alt_off;
			default:                      op_dec = op_none;
		endcase
	end

	// Unknown codes give no command
	always_ff @(posedge clk_sys or posedge reset) begin
		if (reset) begin
			cmd <= '0;
		end else begin
			cmd.valid <= event_q && (op_dec != op_none);
			cmd.op    <= op_dec;
		end
	end

endmodule

//--- rtl/crop_offsets.sv
//////////////////////////////////////////////////////////////////////
// Crop offset registers
// Alt modifier state, direction steps, clear and preset load
//////////////////////////////////////////////////////////////////////

`timescale 1ns/100ps

module crop_offsets (
	input  logic                    clk_sys,
	input  logic                    reset,
	input  screen_pkg::adjust_cmd_t cmd,
	input  logic                    preset_load,  // One cycle strobe
	input  screen_pkg::crop_t       preset,
	output screen_pkg::crop_t       crop
);
	import screen_pkg::*;

	logic alt;  // Steers keys to the right and bottom edges

	always_ff @(posedge clk_sys or posedge reset) begin
		if (reset) begin
			alt <= 1'b0;
		end else if (cmd.valid) begin
			if (cmd.op == op_alt_on)
				alt <= 1'b1;
			else if (cmd.op == op_alt_off)
				alt <= 1'b0;
		end
	end

	// Preset has priority over a key in the same cycle
	always_ff @(posedge clk_sys or posedge reset) begin
		if (reset) begin
			crop <= '0;
		end else if (preset_load) begin
			crop <= preset;
		end else if (cmd.valid) begin
			case (cmd.op)
				op_clear: crop <= '0;
				op_up: begin
					if (alt)
						crop.vbl_b <= crop.vbl_b + 12'd1;
					else
						crop.vbl_t <= crop.vbl_t + 12'd1;
				end
				op_down: begin
					if (alt)
						crop.vbl_b <= crop.vbl_b - 12'd1;
					else
						crop.vbl_t <= crop.vbl_t - 12'd1;
				end
				op_left: begin
					if (alt)
						crop.hbl_r <= crop.hbl_r + hstep;
					else
						crop.hbl_l <= crop.hbl_l + hstep;
				end
				op_right: begin
					if (alt)
						crop.hbl_r <= crop.hbl_r - hstep;
					else
						crop.hbl_l <= crop.hbl_l - hstep;
				end
				default: ;  // Alt and none leave offsets alone
			endcase
		end
	end

endmodule

//--- rtl/line_timing.sv
//////////////////////////////////////////////////////////////////////
// Horizontal timing
// Pixel counter, blank and sync edge positions, line width
// Shifted and forced horizontal blank combined into hbl
//////////////////////////////////////////////////////////////////////

`timescale 1ns/100ps

module line_timing #(
	parameter int COUNT_W      = 12,
	parameter int FORCE_MARGIN = 8
) (
	input  logic                  clk_sys,
	input  logic                  reset,
	input  screen_pkg::video_in_t video,
	input  screen_pkg::crop_t     crop,
	output logic                  hbl,         // Combined horizontal blank
	output logic                  line_start,  // Falling edge of hs_n
	output screen_pkg::count_t    hsize,
	input  screen_pkg::count_t    vcnt
);
	import screen_pkg::*;

	logic [COUNT_W-1:0] hcnt;
	logic [COUNT_W-1:0] hend;  // Start of active area
	logic [COUNT_W-1:0] hsta;  // Start of blank
	logic [COUNT_W-1:0] hmax;  // Line length
	logic [COUNT_W-1:0] shbl_off_at;
	logic [COUNT_W-1:0] shbl_on_at;
	logic [COUNT_W-1:0] fhbl_on_at;
	logic               hs_q;
	logic               hblank_q;
	logic               hblank_fall;
	logic               hblank_rise;
	logic               shbl;
	logic               fhbl;

	assign hblank_fall = hblank_q & ~video.hblank;
	assign hblank_rise = ~hblank_q & video.hblank;
	assign line_start  = hs_q & ~video.hs_n;

	// Two counts early to line up with the blank and enable registers
	assign shbl_off_at = COUNT_W'(hend + crop.hbl_l - 12'd2);
	assign shbl_on_at  = COUNT_W'(hsta + crop.hbl_r - 12'd2);
	assign fhbl_on_at  = hmax - COUNT_W'(FORCE_MARGIN);

	always_ff @(posedge clk_sys or posedge reset) begin
		if (reset) begin
			hs_q     <= 1'b0;
			hblank_q <= 1'b0;
			hcnt     <= '0;
			hend     <= '0;
			hsta     <= '0;
			hmax     <= '0;
			hsize    <= '0;
			shbl     <= 1'b0;
			fhbl     <= 1'b0;
			hbl      <= 1'b1;
		end else begin
			hs_q     <= video.hs_n;
			hblank_q <= video.hblank;
			hcnt     <= video.hs_n ? hcnt + 1'b1 : '0;  // Held at 0 in sync

			if (hblank_fall)
				hend <= hcnt;
			if (hblank_rise) begin
				hsta <= hcnt;
				if (vcnt == 12'd1)
					hsize <= count_t'(hcnt - hend);  // Width sampled once per frame
			end
			if (line_start)
				hmax <= hcnt;

			if (hcnt == shbl_off_at)
				shbl <= 1'b0;
			if (hcnt == shbl_on_at)
				shbl <= 1'b1;

			// Keep a margin blanked at both ends of the line
			fhbl <= (hcnt < COUNT_W'(FORCE_MARGIN)) || (hcnt >= fhbl_on_at);

			hbl <= shbl | fhbl | ~video.hs_n;
		end
	end

endmodule

//--- rtl/frame_timing.sv
//////////////////////////////////////////////////////////////////////
// Vertical timing
// Line counter, frame edge positions and frame height
// Shifted and forced vertical blank, display enables, frame start
//////////////////////////////////////////////////////////////////////

`timescale 1ns/100ps

module frame_timing #(
	parameter int COUNT_W = 12
) (
	input  logic                  clk_sys,
	input  logic                  reset,
	input  screen_pkg::video_in_t video,
	input  screen_pkg::crop_t     crop,
	input  logic                  hbl,
	input  logic                  line_start,
	input  screen_pkg::count_t    hsize,
	output screen_pkg::count_t    vcnt,
	output screen_pkg::geometry_t geometry,
	output logic                  frame_start,  // Falling edge of vblank
	output logic                  hde,
	output logic                  vde
);
	import screen_pkg::*;

	logic [COUNT_W-1:0] vcnt_q;
	logic [COUNT_W-1:0] vend;    // First active line
	logic [COUNT_W-1:0] vmax;    // Line count at blank start
	logic [COUNT_W-1:0] vs_end;  // Line where vsync ends
	logic [COUNT_W-1:0] svbl_off_at;
	logic [COUNT_W-1:0] svbl_on_at;
	count_t             vsize;
	logic               vblank_q;
	logic               vs_q;
	logic               hbl_q;
	logic               vblank_rise;
	logic               hbl_fall;
	logic               svbl;
	logic               fvbl;

	assign vblank_rise = ~vblank_q & video.vblank;
	assign frame_start = vblank_q & ~video.vblank;
	assign hbl_fall    = hbl_q & ~hbl;
	assign vcnt        = count_t'(vcnt_q);
	assign geometry    = {hsize, vsize};

	assign svbl_off_at = COUNT_W'(vend + crop.vbl_t);
	// Bottom offset with top bit set counts back from the frame end
	assign svbl_on_at  = crop.vbl_b[11] ? COUNT_W'(vmax + crop.vbl_b) : COUNT_W'(crop.vbl_b);

	always_ff @(posedge clk_sys or posedge reset) begin
		if (reset) begin
			vblank_q <= 1'b0;
			vs_q     <= 1'b0;
			hbl_q    <= 1'b0;
			vcnt_q   <= '0;
			vend     <= '0;
			vmax     <= '0;
			vs_end   <= '0;
			vsize    <= '0;
			svbl     <= 1'b0;
			fvbl     <= 1'b0;
			hde      <= 1'b0;
			vde      <= 1'b0;
		end else begin
			vblank_q <= video.vblank;
			vs_q     <= video.vs_n;
			hbl_q    <= hbl;

			if (vblank_rise)
				vcnt_q <= '0;
			else if (line_start)
				vcnt_q <= vcnt_q + 1'b1;

			if (frame_start)
				vend <= vcnt_q;
			if (~vs_q & video.vs_n)
				vs_end <= vcnt_q;
			if (vblank_rise) begin
				vmax  <= vcnt_q;
				vsize <= count_t'(vcnt_q - vend);
			end

			// Vertical blanks only move at the start of an active line
			if (hbl_fall) begin
				if (vcnt_q == svbl_off_at)
					svbl <= 1'b0;
				if (vcnt_q == svbl_on_at)
					svbl <= 1'b1;
				if (vcnt_q == vmax - 1'b1)
					fvbl <= 1'b1;
				if (vcnt_q == vs_end + 2'd2)
					fvbl <= 1'b0;
			end

			hde <= ~hbl;
			vde <= ~(svbl | fvbl);
		end
	end

endmodule

//--- rtl/screen_info.sv
//////////////////////////////////////////////////////////////////////
// Per frame status snapshot
// Crop offsets and measured geometry, change counter on size change
//////////////////////////////////////////////////////////////////////

`timescale 1ns/100ps

module screen_info (
	input  logic                     clk_sys,
	input  logic                     reset,
	input  logic                     frame_start,
	input  screen_pkg::crop_t        crop,
	input  screen_pkg::geometry_t    geometry,
	output screen_pkg::screen_info_t info
);

	logic geom_changed;

	// Compare against the previous snapshot
	assign geom_changed = (geometry != info.geometry);

	always_ff @(posedge clk_sys or posedge reset) begin
		if (reset) begin
			info <= '0;
		end else if (frame_start) begin
			info.crop     <= crop;
			info.geometry <= geometry;
			if (geom_changed)
				info.change_count <= info.change_count + 7'd1;  // Wraps at 7 bits
		end
	end

endmodule

//--- rtl/screen_adjust_top.sv
//////////////////////////////////////////////////////////////////////
// Screen area adjustment top level
// Key decode, crop offsets, line and frame timing, status snapshot
//////////////////////////////////////////////////////////////////////

`timescale 1ns/100ps

module screen_adjust_top #(
	parameter int COUNT_W      = 12,
	parameter int FORCE_MARGIN = 8
) (
	input  logic                     clk_sys,
	input  logic                     reset,
	input  screen_pkg::video_in_t    video,
	input  logic [7:0]               kbd_data,
	input  logic [1:0]               kbd_type,
	input  logic                     kbd_level,
	input  logic                     preset_load,
	input  screen_pkg::crop_t        preset,
	output logic                     hde,
	output logic                     vde,
	output screen_pkg::screen_info_t info
);
	import screen_pkg::*;

	adjust_cmd_t cmd;
	crop_t       crop;
	logic        hbl;
	logic        line_start;
	count_t      hsize;
	count_t      vcnt;
	geometry_t   geometry;
	logic        frame_start;

	key_decode u_key_decode (
		.clk_sys   (clk_sys),
		.reset     (reset),
		.kbd_data  (kbd_data),
		.kbd_type  (kbd_type),
		.kbd_level (kbd_level),
		.cmd       (cmd)
	);

	crop_offsets u_crop_offsets (
		.clk_sys     (clk_sys),
		.reset       (reset),
		.cmd         (cmd),
		.preset_load (preset_load),
		.preset      (preset),
		.crop        (crop)
	);

	line_timing #(
		.COUNT_W      (COUNT_W),
		.FORCE_MARGIN (FORCE_MARGIN)
	) u_line_timing (
		.clk_sys    (clk_sys),
		.reset      (reset),
		.video      (video),
		.crop       (crop),
		.hbl        (hbl),
		.line_start (line_start),
		.hsize      (hsize),
		.vcnt       (vcnt)  // Line number for the width sample
	);

	frame_timing #(
		.COUNT_W (COUNT_W)
	) u_frame_timing (
		.clk_sys     (clk_sys),
		.reset       (reset),
		.video       (video),
		.crop        (crop),
		.hbl         (hbl),
		.line_start  (line_start),
		.hsize       (hsize),
		.vcnt        (vcnt),
		.geometry    (geometry),
		.frame_start (frame_start),
		.hde         (hde),
		.vde         (vde)
	);

	screen_info u_screen_info (
		.clk_sys     (clk_sys),
		.reset       (reset),
		.frame_start (frame_start),
		.crop        (crop),
		.geometry    (geometry),
		.info        (info)
	);

endmodule

//--- verification/screen_adjust_assert.sv
//////////////////////////////////////////////////////////////////////
// Concurrent assertions bound to the screen adjust top level
// Command pulse width, hde during sync, enables after reset
//////////////////////////////////////////////////////////////////////

`timescale 1ns/100ps

module screen_adjust_assert (
	input logic clk_sys,
	input logic reset,
	input logic cmd_valid,
	input logic hs_n,
	input logic hde,
	input logic vde
);

	// One cycle pulse per key event
	cmd_single_cycle: assert property (@(posedge clk_sys) disable iff (reset)
		cmd_valid |=> !cmd_valid)
		else $error("cmd.valid held for more than one cycle");

	// hde trails sync through the blank and enable registers
	hde_off_in_sync: assert property (@(posedge clk_sys) disable iff (reset)
		!hs_n |-> ##2 !hde)
		else $error("hde high during horizontal sync");

	enables_off_after_reset: assert property (@(posedge clk_sys)
		$fell(reset) |-> (!hde && !vde))
		else $error("hde or vde high right after reset");

endmodule

bind screen_adjust_top screen_adjust_assert u_screen_adjust_assert (
	.clk_sys   (clk_sys),
	.reset     (reset),
	.cmd_valid (cmd.valid),
	.hs_n      (video.hs_n),  // Sync as seen at the top level input
	.hde       (hde),
	.vde       (vde)
);

//--- verification/tb_screen_adjust.sv
//////////////////////////////////////////////////////////////////////
// Testbench for the screen area adjustment top level
// Clock, reset, video pattern generator and keyboard driver
// Directed tests with a crop model, value checker and watchdog
//////////////////////////////////////////////////////////////////////

`timescale 1ns/100ps

module tb_screen_adjust;
	import screen_pkg::*;

	localparam int clk_period      = 8;
	localparam int h_total         = 100;
	localparam int h_sync          = 10;
	localparam int h_act_start     = 20;
	localparam int h_active        = 60;
	localparam int v_total         = 40;
	localparam int v_sync          = 3;
	localparam int v_act_start     = 6;
	localparam int v_act_end       = 36;
	localparam int test_frames     = 11;  // Frames over all tests
	localparam int watchdog_cycles = (test_frames + 3) * h_total * v_total;

	logic         clk_sys = 1'b0;
	logic         reset   = 1'b1;
	video_in_t    video;
	logic [7:0]   kbd_data;
	logic [1:0]   kbd_type;
	logic         kbd_level;
	logic         preset_load;
	crop_t        preset;
	logic         hde;
	logic         vde;
	screen_info_t info;

	crop_t       model_crop;  // Expected offsets
	logic        model_alt;
	int          line_hde;    // hde cycles counted on line 20
	logic        vde_active;  // vde mid line 20
	logic        vde_sync;    // vde mid line 1, inside vsync
	int unsigned lcg_state = 22;

	screen_adjust_top u_screen_adjust_top (
		.clk_sys     (clk_sys),
		.reset       (reset),
		.video       (video),
		.kbd_data    (kbd_data),
		.kbd_type    (kbd_type),
		.kbd_level   (kbd_level),
		.preset_load (preset_load),
		.preset      (preset),
		.hde         (hde),
		.vde         (vde),
		.info        (info)
	);

	initial begin
		forever #(clk_period / 2) clk_sys = ~clk_sys;
	end

	task automatic check_value(input string name, input logic [63:0] got,
		input logic [63:0] exp);
		if (got !== exp) begin
			$display("[FAIL] t=%0t %s: got %0h, expected %0h", $time, name, got, exp);
			$display("Something failed");
			$fatal(1, "Stopped at first mismatch");
		end
	endtask

	function automatic logic [31:0] lcg_next();
		lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
		return lcg_state >> 16;
	endfunction

	// Alt steers vertical keys to the bottom and horizontal keys to the right
	task automatic update_model(input logic [7:0] code);
		count_t step;
		logic   vertical;
		case (code)
			key_up:    step = 12'd1;
			key_down:  step = 12'hFFF;  // Minus one at 12 bits
			key_left:  step = hstep;
			key_right: step = -hstep;
			default:   step = 12'd0;
		endcase
		vertical = (code == key_up) || (code == key_down);
		if (vertical && model_alt)
			model_crop.vbl_b = model_crop.vbl_b + step;
		else if (vertical)
			model_crop.vbl_t = model_crop.vbl_t + step;
		else if (model_alt)
			model_crop.hbl_r = model_crop.hbl_r + step;
		else
			model_crop.hbl_l = model_crop.hbl_l + step;
		if (code == key_alt_l || code == key_alt_r)
			model_alt = 1'b1;
		if (code == key_alt_l_rel || code == key_alt_r_rel)
			model_alt = 1'b0;
		if (code == key_backspace)
			model_crop = '0;
	endtask

	task automatic send_key(input logic [7:0] code);
		@(posedge clk_sys);
		kbd_type  <= kbd_key_type;
		kbd_data  <= code;
		kbd_level <= ~kbd_level;  // Toggle marks a new event
		repeat (4) @(posedge clk_sys);
		update_model(code);
	endtask

	task automatic gen_frames(input int frames, input int active_w);
		for (int f = 0; f < frames; f++)
			for (int y = 0; y < v_total; y++)
				for (int x = 0; x < h_total; x++) begin
					@(posedge clk_sys);
					if (y == 20) begin
						if (x == 0)
							line_hde = 0;
						line_hde += int'(hde);
					end
					if (x == h_total / 2) begin
						if (y == 20)
							vde_active = vde;
						if (y == 1)
							vde_sync = vde;
					end
					video.hs_n   <= (x >= h_sync);
					video.vs_n   <= (y >= v_sync);
					video.hblank <= !(x >= h_act_start && x < h_act_start + active_w);
					video.vblank <= !(y >= v_act_start && y < v_act_end);
				end
	endtask

	task automatic test_geometry();
		gen_frames(2, h_active);
		check_value("info.geometry.hsize", info.geometry.hsize, h_active);
		check_value("info.geometry.vsize", info.geometry.vsize, v_act_end - v_act_start);
		check_value("hde cycles per line", line_hde, h_active);
		check_value("vde on active line", vde_active, 1'b1);
		check_value("vde in vertical sync", vde_sync, 1'b0);
		check_value("info.crop", info.crop, '0);
	endtask

	task automatic test_alt_keys();
		send_key(key_up);
		send_key(key_alt_l);
		send_key(key_left);
		send_key(key_alt_l_rel);
		gen_frames(1, h_active);
		check_value("info.crop.vbl_t", info.crop.vbl_t, 1);
		check_value("info.crop.hbl_r", info.crop.hbl_r, 4);
		check_value("info.crop.hbl_l", info.crop.hbl_l, 0);
		check_value("info.crop.vbl_b", info.crop.vbl_b, 0);
	endtask

	task automatic test_random_keys();
		logic [7:0] codes [6] = '{key_up, key_down, key_left, key_right,
			key_alt_r, key_alt_r_rel};
		for (int i = 0; i < 16; i++)
			send_key(codes[lcg_next() % 6]);
		send_key(key_alt_r_rel);
		gen_frames(1, h_active);
		check_value("info.crop", info.crop, model_crop);
	endtask

	task automatic test_clear();
		send_key(key_backspace);
		gen_frames(1, h_active);
		check_value("info.crop", info.crop, '0);
	endtask

	task automatic test_preset();
		crop_t chosen = '{hbl_l: 12'h014, hbl_r: 12'hFF8, vbl_t: 12'h002, vbl_b: 12'h803};
		@(posedge clk_sys);
		preset      <= chosen;
		preset_load <= 1'b1;
		@(posedge clk_sys);
		preset_load <= 1'b0;
		model_crop = chosen;
		gen_frames(1, h_active);
		check_value("info.crop", info.crop, chosen);
	endtask

	// Width change shows up one frame after it is measured
	task automatic test_change_count();
		logic [6:0] base;
		base = info.change_count;
		gen_frames(2, h_active);
		check_value("info.change_count", info.change_count, base);
		gen_frames(3, 50);
		check_value("info.change_count", info.change_count, 7'(base + 7'd1));
		check_value("info.geometry.hsize", info.geometry.hsize, 50);
	endtask

	initial begin
		video       = '{hs_n: 1'b1, vs_n: 1'b1, hblank: 1'b1, vblank: 1'b1};
		kbd_data    = '0;
		kbd_type    = '0;
		kbd_level   = 1'b0;
		preset_load = 1'b0;
		preset      = '0;
		model_crop  = '0;
		model_alt   = 1'b0;
		line_hde    = 0;
		repeat (10) @(posedge clk_sys);
		reset <= 1'b0;
		test_geometry();
		test_alt_keys();
		test_random_keys();
		test_clear();
		test_preset();
		test_change_count();
		$display("Everything OK");
		$finish;
	end

	initial begin
		#(watchdog_cycles * clk_period);
		$display("Watchdog timeout, the tests did not finish in time");
		$display("Something failed");
		$fatal(1, "Timeout");
	end

endmodule

//--- verilog.f
rtl/screen_pkg.sv
rtl/key_decode.sv
rtl/crop_offsets.sv
rtl/line_timing.sv
rtl/frame_timing.sv
rtl/screen_info.sv
rtl/screen_adjust_top.sv
verification/screen_adjust_assert.sv
verification/tb_screen_adjust.sv
